// File: list.f
source/dtlb_pkg.sv
source/l2_bus_pkg.sv
source/tlb_plru.sv
source/tlb_entry_array.sv
source/tlb_miss_arbiter.sv
source/tlb_fence_ctrl.sv
source/dtlb_top.sv
sim/tb_clock_gen.sv
sim/tb_l2_model.sv
sim/dtlb_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module dtlb_tb \
    --Mdir obj_dir \
    -o sim_dtlb \
    -f list.f

out=$(./obj_dir/sim_dtlb)
echo "$out"

if grep -qx "Done: no errors" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: sim/dtlb_tb.sv
`default_nettype none

module dtlb_tb;

    localparam logic [19:0] PPN_MASK = 20'h5A5A5;
    localparam int          TIMEOUT  = 50;

    typedef enum int {
        OP_LOOKUP,
        OP_MISS,
        OP_DUAL,
        OP_FENCE,
        OP_CAP
    } op_e;

    typedef struct {
        string name;
        op_e   op;
        int    port;
        int    pa;
        int    pb;
        int    asid;
        bit    all_addr;
        bit    all_asid;
        bit    exp_hit;
        bit    exp_err;
    } test_t;

    logic                 clk;
    logic                 rst;
    dtlb_pkg::asid_t      asid;
    logic                 ld_req;
    dtlb_pkg::vaddr_t     ld_vaddr;
    logic                 st_req;
    dtlb_pkg::vaddr_t     st_vaddr;
    logic                 fence;
    dtlb_pkg::fence_req_t fence_req;
    logic                 l2_resp_valid;
    l2_bus_pkg::l2_resp_t l2_resp;
    logic                 ld_hit;
    dtlb_pkg::paddr_t     ld_paddr;
    logic                 st_hit;
    dtlb_pkg::paddr_t     st_paddr;
    logic                 ld_cancel;
    logic                 st_cancel;
    logic                 ld_wb;
    logic                 st_wb;
    logic                 wb_error;
    logic                 l2_req_valid;
    l2_bus_pkg::l2_req_t  l2_req;
    logic                 fence_busy;

    test_t          tests[$];
    dtlb_pkg::vpn_t pg[16];
    string          cur_name;
    int             test_err;
    int             total_err;
    int             failed;

    tb_clock_gen u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    dtlb_top #(
        .DEPTH (8)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .asid_i          (asid),
        .ld_req_i        (ld_req),
        .ld_vaddr_i      (ld_vaddr),
        .st_req_i        (st_req),
        .st_vaddr_i      (st_vaddr),
        .fence_i         (fence),
        .fence_req_i     (fence_req),
        .l2_resp_valid_i (l2_resp_valid),
        .l2_resp_i       (l2_resp),
        .ld_hit_o        (ld_hit),
        .ld_paddr_o      (ld_paddr),
        .st_hit_o        (st_hit),
        .st_paddr_o      (st_paddr),
        .ld_cancel_o     (ld_cancel),
        .st_cancel_o     (st_cancel),
        .ld_wb_o         (ld_wb),
        .st_wb_o         (st_wb),
        .wb_error_o      (wb_error),
        .l2_req_valid_o  (l2_req_valid),
        .l2_req_o        (l2_req),
        .fence_busy_o    (fence_busy)
    );

    tb_l2_model #(
        .DELAY (3)
    ) u_l2 (
        .clk          (clk),
        .req_valid_i  (l2_req_valid),
        .req_i        (l2_req),
        .resp_valid_o (l2_resp_valid),
        .resp_o       (l2_resp)
    );

    // ------------------------------------------------------------
    // helpers.
    // ------------------------------------------------------------
    function automatic void add_test(string name, op_e op, int port, int pa, int pb,
                                     int asid_v, bit all_addr, bit all_asid,
                                     bit exp_hit, bit exp_err);
        test_t t;
        t.name     = name;
        t.op       = op;
        t.port     = port;
        t.pa       = pa;
        t.pb       = pb;
        t.asid     = asid_v;
        t.all_addr = all_addr;
        t.all_asid = all_asid;
        t.exp_hit  = exp_hit;
        t.exp_err  = exp_err;
        tests.push_back(t);
    endfunction

    // translation the l2 model gives, with the offset kept.
    function automatic logic [31:0] expect_paddr(dtlb_pkg::vpn_t vpn, logic [11:0] ofs);
        return {vpn ^ PPN_MASK, ofs};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %h actual %h", cur_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic clear_inputs();
        ld_req    = 1'b0;
        st_req    = 1'b0;
        fence     = 1'b0;
        fence_req = '0;
    endtask

    task automatic wait_wb(output logic ld_seen, output logic st_seen, output logic err);
        int  n;
        bit  done;
        n       = 0;
        done    = 0;
        ld_seen = 1'b0;
        st_seen = 1'b0;
        err     = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            if (ld_wb || st_wb) begin
                ld_seen = ld_wb;
                st_seen = st_wb;
                err     = wb_error;
                done    = 1;
            end
            n++;
        end
        if (!done) begin
            $display("%s: no write-back pulse within %0d cycles", cur_name, TIMEOUT);
            test_err++;
        end
    endtask

    task automatic wait_fence_done();
        int n;
        n = 0;
        while (fence_busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (fence_busy) begin
            $display("%s: fence still busy after %0d cycles", cur_name, TIMEOUT);
            test_err++;
        end
    endtask

    task automatic drive_port(int port, dtlb_pkg::vpn_t vpn, logic [11:0] ofs);
        if (port == 0) begin
            ld_req   = 1'b1;
            ld_vaddr = {vpn, ofs};
        end else begin
            st_req   = 1'b1;
            st_vaddr = {vpn, ofs};
        end
    endtask

    // ------------------------------------------------------------
    // operations.
    // ------------------------------------------------------------
    task automatic run_lookup(test_t t);
        logic [11:0] ofs;
        logic        hit;
        logic [31:0] pa;
        logic        lw;
        logic        sw;
        logic        er;
        ofs = 12'($urandom);
        step();
        asid = dtlb_pkg::asid_t'(t.asid);
        drive_port(t.port, pg[t.pa], ofs);
        @(negedge clk);
        hit  = (t.port == 0) ? ld_hit : st_hit;
        pa   = (t.port == 0) ? ld_paddr : st_paddr;
        step();
        clear_inputs();
        check("hit", 32'(t.exp_hit), 32'(hit));
        if (t.exp_hit && hit) begin
            check("paddr", expect_paddr(pg[t.pa], ofs), pa);
        end
        if (!hit) begin
            wait_wb(lw, sw, er);
            if (t.op == OP_MISS) begin
                check("load wb", 32'(t.port == 0), 32'(lw));
                check("store wb", 32'(t.port == 1), 32'(sw));
                check("wb error", 32'(t.exp_err), 32'(er));
            end
        end
    endtask

    task automatic run_dual(test_t t);
        logic lw;
        logic sw;
        logic er;
        step();
        asid = dtlb_pkg::asid_t'(t.asid);
        drive_port(0, pg[t.pa], 12'h010);
        drive_port(1, pg[t.pb], 12'h020);
        @(negedge clk);
        check("load hit", 0, 32'(ld_hit));
        check("store hit", 0, 32'(st_hit));
        step();
        st_req = 1'b0;
        @(negedge clk);
        check("req valid", 1, 32'(l2_req_valid));
        check("req src", 32'(l2_bus_pkg::SRC_STORE), 32'(l2_req.src));
        check("req vpn", 32'(pg[t.pb]), 32'(l2_req.vpn));
        check("load cancel", 1, 32'(ld_cancel));
        check("store cancel", 0, 32'(st_cancel));
        step();
        clear_inputs();
        @(negedge clk);
        // load retried while the store request is outstanding.
        check("outstanding cancel", 1, 32'(ld_cancel));
        check("second req", 0, 32'(l2_req_valid));
        wait_wb(lw, sw, er);
        check("store wb", 1, 32'(sw));
        check("wb error", 0, 32'(er));
    endtask

    task automatic run_fence(test_t t);
        logic hit;
        step();
        asid               = dtlb_pkg::asid_t'(t.asid);
        fence              = 1'b1;
        fence_req.all_addr = t.all_addr;
        fence_req.all_asid = t.all_asid;
        fence_req.vpn      = pg[t.pa];
        fence_req.asid     = dtlb_pkg::asid_t'(t.asid);
        step();
        fence = 1'b0;
        drive_port(0, pg[t.pb], 12'h0);
        @(negedge clk);
        check("busy", 1, 32'(fence_busy));
        hit = ld_hit;
        step();
        clear_inputs();
        @(negedge clk);
        check("probe hit", 32'(t.exp_hit), 32'(hit));
        check("cancel while busy", 1, 32'(ld_cancel));
        wait_fence_done();
    endtask

    task automatic run_capacity(test_t t);
        int          hits;
        logic        last_hit;
        logic [11:0] ofs;
        step();
        asid               = dtlb_pkg::asid_t'(t.asid);
        fence              = 1'b1;
        fence_req.all_addr = 1'b1;
        fence_req.all_asid = 1'b0;
        fence_req.vpn      = '0;
        fence_req.asid     = 9'h1FF;
        hits               = 0;
        last_hit           = 1'b0;
        // probes ride on an unrelated sweep, so their misses are only cancelled.
        for (int i = 0; i < 9; i += 2) begin
            step();
            clear_inputs();
            ofs = 12'($urandom);
            drive_port(0, pg[t.pa + i], ofs);
            if (i + 1 < 9) begin
                drive_port(1, pg[t.pa + i + 1], ofs);
            end
            @(negedge clk);
            if (!fence_busy) begin
                $display("%s: fence ended before the probes finished", cur_name);
                test_err++;
            end
            if (ld_hit) begin
                hits++;
                check("load paddr", expect_paddr(pg[t.pa + i], ofs), ld_paddr);
                if (i == 8) last_hit = 1'b1;
            end
            if (i + 1 < 9 && st_hit) begin
                hits++;
                check("store paddr", expect_paddr(pg[t.pa + i + 1], ofs), st_paddr);
            end
        end
        step();
        clear_inputs();
        wait_fence_done();
        check("hit count", 8, 32'(hits));
        check("last fill hit", 1, 32'(last_hit));
    endtask

    // ------------------------------------------------------------
    // stimulus table and main loop.
    // ------------------------------------------------------------
    task automatic build_table();
        add_test("refill_load", OP_MISS, 0, 0, 0, 1, 0, 0, 0, 0);
        add_test("hit_load", OP_LOOKUP, 0, 0, 0, 1, 0, 0, 1, 0);
        add_test("refill_store_global", OP_MISS, 1, 1, 0, 1, 0, 0, 0, 0);
        add_test("hit_store_global", OP_LOOKUP, 1, 1, 0, 1, 0, 0, 1, 0);
        add_test("asid_private_miss", OP_LOOKUP, 0, 0, 0, 2, 0, 0, 0, 0);
        add_test("asid_global_hit", OP_LOOKUP, 0, 1, 0, 2, 0, 0, 1, 0);
        add_test("dual_miss", OP_DUAL, 0, 3, 4, 1, 0, 0, 0, 0);
        add_test("store_after_dual", OP_LOOKUP, 1, 4, 0, 1, 0, 0, 1, 0);
        add_test("error_response", OP_MISS, 0, 2, 0, 1, 0, 0, 0, 1);
        add_test("error_not_filled", OP_LOOKUP, 0, 2, 0, 1, 0, 0, 0, 0);
        add_test("fence_single", OP_FENCE, 0, 0, 15, 1, 0, 0, 0, 0);
        add_test("fence_kept_asid", OP_LOOKUP, 0, 0, 0, 2, 0, 0, 1, 0);
        add_test("fence_kept_page", OP_LOOKUP, 1, 4, 0, 1, 0, 0, 1, 0);
        add_test("fence_removed", OP_LOOKUP, 0, 0, 0, 1, 0, 0, 0, 0);
        add_test("fence_asid", OP_FENCE, 0, 0, 15, 1, 1, 0, 0, 0);
        add_test("fence_asid_kept", OP_LOOKUP, 0, 0, 0, 2, 0, 0, 1, 0);
        add_test("fence_asid_removed", OP_LOOKUP, 1, 4, 0, 1, 0, 0, 0, 0);
        add_test("fence_global_removed", OP_LOOKUP, 0, 1, 0, 2, 0, 0, 0, 0);
        add_test("fence_all", OP_FENCE, 0, 0, 15, 1, 1, 1, 0, 0);
        for (int i = 0; i < 9; i++) begin
            add_test($sformatf("fill_%0d", i), OP_MISS, i % 2, 5 + i, 0, 1, 0, 0, 0, 0);
        end
        add_test("capacity", OP_CAP, 0, 5, 0, 1, 0, 0, 0, 0);
    endtask

    // distinct random pages with page 1 global and page 2 answered with an error.
    task automatic make_pages();
        bit dup;
        for (int i = 0; i < 16; i++) begin
            do begin
                pg[i]     = 20'($urandom);
                pg[i][19] = 1'b0;
                if (pg[i][3:0] == 4'hF) pg[i][3:0] = 4'h0;
                dup = 0;
                for (int j = 0; j < i; j++) begin
                    if (pg[j] == pg[i]) dup = 1;
                end
            end while (dup);
        end
        pg[1][19]  = 1'b1;
        pg[2][3:0] = 4'hF;
    endtask

    initial begin
        int n;
        void'($urandom(43973));
        asid      = 9'd1;
        ld_req    = 1'b0;
        ld_vaddr  = '0;
        st_req    = 1'b0;
        st_vaddr  = '0;
        fence     = 1'b0;
        fence_req = '0;
        total_err = 0;
        failed    = 0;
        make_pages();
        build_table();
        n = 0;
        while (!rst && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!rst) begin
            $display("reset never released");
            total_err++;
        end
        foreach (tests[i]) begin
            cur_name = tests[i].name;
            test_err = 0;
            case (tests[i].op)
                OP_DUAL:  run_dual(tests[i]);
                OP_FENCE: run_fence(tests[i]);
                OP_CAP:   run_capacity(tests[i]);
                default:  run_lookup(tests[i]);
            endcase
            if (test_err == 0) begin
                $display("ok   %s", cur_name);
            end else begin
                $display("FAIL %s", cur_name);
                failed++;
            end
            total_err += test_err;
        end
        $display("tests %0d, failed %0d, errors %0d", tests.size(), failed, total_err);
        if (total_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_l2_model.sv
`default_nettype none

module tb_l2_model #(
    parameter int DELAY = 3
) (
    input  logic                 clk,
    input  logic                 req_valid_i,
    input  l2_bus_pkg::l2_req_t  req_i,
    output logic                 resp_valid_o,
    output l2_bus_pkg::l2_resp_t resp_o
);

    localparam logic [19:0] PPN_MASK = 20'h5A5A5;

    l2_bus_pkg::l2_req_t req_q;
    logic                pending;
    int                  count;

    initial begin
        resp_valid_o = 1'b0;
        resp_o       = '0;
        req_q        = '0;
        pending      = 1'b0;
        count        = 0;
    end

    // one request at a time, answered DELAY cycles after it is seen.
    always @(posedge clk) begin
        #1;
        resp_valid_o = 1'b0;
        if (pending) begin
            if (count == 1) begin
                resp_valid_o = 1'b1;
                resp_o.src   = req_q.src;
                resp_o.vpn   = req_q.vpn;
                resp_o.ppn   = req_q.vpn ^ PPN_MASK;
                resp_o.g     = req_q.vpn[19];
                resp_o.error = (req_q.vpn[3:0] == 4'hF);
                pending      = 1'b0;
            end else begin
                count = count - 1;
            end
        end
        if (req_valid_i) begin
            pending = 1'b1;
            count   = DELAY;
            req_q   = req_i;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // period of 4, reset held low for 8 cycles.
    initial begin
        clk_o = 1'b0;
        rst_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_o = 1'b1;
    end

    always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: source/dtlb_top.sv
`default_nettype none

module dtlb_top #(
    parameter  int DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dtlb_pkg::asid_t      asid_i,
    input  logic                 ld_req_i,
    input  dtlb_pkg::vaddr_t     ld_vaddr_i,
    input  logic                 st_req_i,
    input  dtlb_pkg::vaddr_t     st_vaddr_i,
    input  logic                 fence_i,
    input  dtlb_pkg::fence_req_t fence_req_i,
    input  logic                 l2_resp_valid_i,
    input  l2_bus_pkg::l2_resp_t l2_resp_i,
    output logic                 ld_hit_o,
    output dtlb_pkg::paddr_t     ld_paddr_o,
    output logic                 st_hit_o,
    output dtlb_pkg::paddr_t     st_paddr_o,
    output logic                 ld_cancel_o,
    output logic                 st_cancel_o,
    output logic                 ld_wb_o,
    output logic                 st_wb_o,
    output logic                 wb_error_o,
    output logic                 l2_req_valid_o,
    output l2_bus_pkg::l2_req_t  l2_req_o,
    output logic                 fence_busy_o
);

    localparam int OFS = dtlb_pkg::PAGE_OFFSET;

    logic                 ld_miss;
    logic                 st_miss;
    logic                 fill;
    dtlb_pkg::tlb_entry_t fill_entry;
    logic                 fence_active;
    dtlb_pkg::fence_req_t fence_cur;
    logic [IDX_W-1:0]     fence_idx;

    // lookups are same cycle, so a miss is known right away.
    assign ld_miss = ld_req_i && !ld_hit_o;
    assign st_miss = st_req_i && !st_hit_o;

    tlb_entry_array #(
        .DEPTH (DEPTH)
    ) u_array (
        .clk            (clk),
        .rst            (rst),
        .ld_req_i       (ld_req_i),
        .ld_vaddr_i     (ld_vaddr_i),
        .st_req_i       (st_req_i),
        .st_vaddr_i     (st_vaddr_i),
        .asid_i         (asid_i),
        .fill_i         (fill),
        .fill_entry_i   (fill_entry),
        .fence_active_i (fence_active),
        .fence_i        (fence_cur),
        .fence_idx_i    (fence_idx),
        .ld_hit_o       (ld_hit_o),
        .ld_paddr_o     (ld_paddr_o),
        .st_hit_o       (st_hit_o),
        .st_paddr_o     (st_paddr_o)
    );

    tlb_miss_arbiter u_arbiter (
        .clk             (clk),
        .rst             (rst),
        .ld_miss_i       (ld_miss),
        .ld_vpn_i        (ld_vaddr_i[31:OFS]),
        .st_miss_i       (st_miss),
        .st_vpn_i        (st_vaddr_i[31:OFS]),
        .fence_busy_i    (fence_busy_o),
        .l2_resp_valid_i (l2_resp_valid_i),
        .l2_resp_i       (l2_resp_i),
        .asid_i          (asid_i),
        .l2_req_valid_o  (l2_req_valid_o),
        .l2_req_o        (l2_req_o),
        .ld_cancel_o     (ld_cancel_o),
        .st_cancel_o     (st_cancel_o),
        .fill_o          (fill),
        .fill_entry_o    (fill_entry),
        .ld_wb_o         (ld_wb_o),
        .st_wb_o         (st_wb_o),
        .wb_error_o      (wb_error_o)
    );

    tlb_fence_ctrl #(
        .DEPTH (DEPTH)
    ) u_fence (
        .clk            (clk),
        .rst            (rst),
        .fence_i        (fence_i),
        .fence_req_i    (fence_req_i),
        .fence_active_o (fence_active),
        .fence_o        (fence_cur),
        .fence_idx_o    (fence_idx),
        .fence_busy_o   (fence_busy_o)
    );

endmodule

`default_nettype wire

// File: source/tlb_fence_ctrl.sv
`default_nettype none

module tlb_fence_ctrl #(
    parameter  int DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fence_i,
    input  dtlb_pkg::fence_req_t fence_req_i,
    output logic                 fence_active_o,
    output dtlb_pkg::fence_req_t fence_o,
    output logic [IDX_W-1:0]     fence_idx_o,
    output logic                 fence_busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        FENCE,
        FENCE_END
    } fence_state_e;

    fence_state_e state_q;

    assign fence_active_o = (state_q == FENCE);
    assign fence_busy_o   = (state_q != IDLE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= IDLE;
            fence_idx_o <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fence_i) begin
                        state_q     <= FENCE;
                        fence_idx_o <= '0;
                    end
                end
                FENCE: begin
                    // single address takes one cycle, a sweep takes DEPTH.
                    if (!fence_o.all_addr || (fence_idx_o == IDX_W'(DEPTH - 1))) begin
                        state_q <= FENCE_END;
                    end else begin
                        fence_idx_o <= fence_idx_o + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request held for the whole fence.
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && fence_i) begin
            fence_o <= fence_req_i;
        end
    end

endmodule

`default_nettype wire

// File: source/tlb_miss_arbiter.sv
`default_nettype none

module tlb_miss_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_miss_i,
    input  dtlb_pkg::vpn_t       ld_vpn_i,
    input  logic                 st_miss_i,
    input  dtlb_pkg::vpn_t       st_vpn_i,
    input  logic                 fence_busy_i,
    input  logic                 l2_resp_valid_i,
    input  l2_bus_pkg::l2_resp_t l2_resp_i,
    input  dtlb_pkg::asid_t      asid_i,
    output logic                 l2_req_valid_o,
    output l2_bus_pkg::l2_req_t  l2_req_o,
    output logic                 ld_cancel_o,
    output logic                 st_cancel_o,
    output logic                 fill_o,
    output dtlb_pkg::tlb_entry_t fill_entry_o,
    output logic                 ld_wb_o,
    output logic                 st_wb_o,
    output logic                 wb_error_o
);

    typedef enum logic {
        IDLE,
        WAIT
    } arb_state_e;

    arb_state_e state_q;
    logic       accept;
    logic       grant_ld;
    logic       grant_st;
    logic       resp_take;

    // store wins when both miss.
    assign accept    = (state_q == IDLE) && !fence_busy_i;
    assign grant_st  = accept && st_miss_i;
    assign grant_ld  = accept && ld_miss_i && !st_miss_i;
    assign resp_take = (state_q == WAIT) && l2_resp_valid_i;

    // fence owns the array, so a response during it is not written.
    assign fill_o             = resp_take && !l2_resp_i.error && !fence_busy_i;
    assign fill_entry_o.valid = 1'b1;
    assign fill_entry_o.vpn   = l2_resp_i.vpn;
    assign fill_entry_o.ppn   = l2_resp_i.ppn;
    assign fill_entry_o.asid  = asid_i;
    assign fill_entry_o.g     = l2_resp_i.g;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q        <= IDLE;
            l2_req_valid_o <= 1'b0;
            ld_cancel_o    <= 1'b0;
            st_cancel_o    <= 1'b0;
            ld_wb_o        <= 1'b0;
            st_wb_o        <= 1'b0;
            wb_error_o     <= 1'b0;
        end else begin
            l2_req_valid_o <= grant_ld || grant_st;
            ld_cancel_o    <= ld_miss_i && !grant_ld;
            st_cancel_o    <= st_miss_i && !grant_st;
            ld_wb_o        <= resp_take && (l2_resp_i.src == l2_bus_pkg::SRC_LOAD);
            st_wb_o        <= resp_take && (l2_resp_i.src == l2_bus_pkg::SRC_STORE);
            wb_error_o     <= resp_take && (l2_resp_i.error || fence_busy_i);
            if (grant_ld || grant_st) begin
                state_q <= WAIT;
            end else if (resp_take) begin
                state_q <= IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_st) begin
            l2_req_o.src <= l2_bus_pkg::SRC_STORE;
            l2_req_o.vpn <= st_vpn_i;
        end else if (grant_ld) begin
            l2_req_o.src <= l2_bus_pkg::SRC_LOAD;
            l2_req_o.vpn <= ld_vpn_i;
        end
    end

endmodule

`default_nettype wire

// File: source/tlb_entry_array.sv
`default_nettype none

module tlb_entry_array #(
    parameter  int DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_req_i,
    input  dtlb_pkg::vaddr_t     ld_vaddr_i,
    input  logic                 st_req_i,
    input  dtlb_pkg::vaddr_t     st_vaddr_i,
    input  dtlb_pkg::asid_t      asid_i,
    input  logic                 fill_i,
    input  dtlb_pkg::tlb_entry_t fill_entry_i,
    input  logic                 fence_active_i,
    input  dtlb_pkg::fence_req_t fence_i,
    input  logic [IDX_W-1:0]     fence_idx_i,
    output logic                 ld_hit_o,
    output dtlb_pkg::paddr_t     ld_paddr_o,
    output logic                 st_hit_o,
    output dtlb_pkg::paddr_t     st_paddr_o
);

    localparam int OFS = dtlb_pkg::PAGE_OFFSET;

    dtlb_pkg::tlb_entry_t entry_q [DEPTH];
    dtlb_pkg::tlb_entry_t ent     [DEPTH];
    logic [DEPTH-1:0]     valid_q;

    dtlb_pkg::vpn_t   ld_vpn;
    dtlb_pkg::vpn_t   st_vpn;
    logic [DEPTH-1:0] ld_match;
    logic [DEPTH-1:0] st_match;
    logic [DEPTH-1:0] fill_match;
    logic [DEPTH-1:0] fence_clr;
    logic [IDX_W-1:0] ld_way;
    logic [IDX_W-1:0] st_way;
    logic [IDX_W-1:0] fill_way;
    logic [IDX_W-1:0] victim;
    logic             fill_we;

    // valid, same page, and same space or global.
    function automatic logic entry_match(input dtlb_pkg::tlb_entry_t e,
                                         input dtlb_pkg::vpn_t vpn,
                                         input dtlb_pkg::asid_t asid);
        return e.valid && (e.vpn == vpn) && ((e.asid == asid) || e.g);
    endfunction

    function automatic logic [IDX_W-1:0] first_set(input logic [DEPTH-1:0] v);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (v[i]) idx = IDX_W'(i);
        end
        return idx;
    endfunction

    // ------------------------------------------------------------
    // lookup and invalidate compare.
    // ------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent[i]       = entry_q[i];
            ent[i].valid = valid_q[i];
        end
    end

    assign ld_vpn = ld_vaddr_i[31:OFS];
    assign st_vpn = st_vaddr_i[31:OFS];

    for (genvar i = 0; i < DEPTH; i++) begin : g_way
        assign ld_match[i]   = entry_match(ent[i], ld_vpn, asid_i);
        assign st_match[i]   = entry_match(ent[i], st_vpn, asid_i);
        assign fill_match[i] = entry_match(ent[i], fill_entry_i.vpn, fill_entry_i.asid);
        assign fence_clr[i]  = ent[i].valid
                             && ((ent[i].vpn == fence_i.vpn)
                                 || (fence_i.all_addr && (fence_idx_i == IDX_W'(i))))
                             && ((ent[i].asid == fence_i.asid) || ent[i].g
                                 || fence_i.all_asid);
    end

    assign ld_way     = first_set(ld_match);
    assign st_way     = first_set(st_match);
    assign ld_hit_o   = ld_req_i && (|ld_match);
    assign st_hit_o   = st_req_i && (|st_match);
    assign ld_paddr_o = {ent[ld_way].ppn, ld_vaddr_i[OFS-1:0]};
    assign st_paddr_o = {ent[st_way].ppn, st_vaddr_i[OFS-1:0]};

    // ------------------------------------------------------------
    // refill placement.
    // ------------------------------------------------------------
    // existing way, then lowest invalid, then plru victim.
    assign fill_way = (|fill_match) ? first_set(fill_match)
                    : (~&valid_q)   ? first_set(~valid_q)
                    : victim;
    assign fill_we  = fill_i && !fence_active_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (fence_active_i) begin
            valid_q <= valid_q & ~fence_clr;
        end else if (fill_i) begin
            valid_q[fill_way] <= fill_entry_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            entry_q[fill_way] <= fill_entry_i;
        end
    end

    tlb_plru #(
        .DEPTH (DEPTH)
    ) u_plru (
        .clk          (clk),
        .rst          (rst),
        .touch_a_i    (ld_hit_o),
        .way_a_i      (ld_way),
        .touch_b_i    (st_hit_o),
        .way_b_i      (st_way),
        .touch_fill_i (fill_we),
        .way_fill_i   (fill_way),
        .victim_o     (victim)
    );

endmodule

`default_nettype wire

// File: source/tlb_plru.sv
`default_nettype none

module tlb_plru #(
    parameter  int DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             touch_a_i,
    input  logic [IDX_W-1:0] way_a_i,
    input  logic             touch_b_i,
    input  logic [IDX_W-1:0] way_b_i,
    input  logic             touch_fill_i,
    input  logic [IDX_W-1:0] way_fill_i,
    output logic [IDX_W-1:0] victim_o
);

    // tree bits in heap order where node n has children 2n+1 and 2n+2.
    logic [DEPTH-2:0] plru_q;
    logic [DEPTH-2:0] plru_d;

    // point every node on the path away from the touched way.
    function automatic logic [DEPTH-2:0] touch(input logic [DEPTH-2:0] bits,
                                               input logic [IDX_W-1:0] way);
        logic [DEPTH-2:0] nb;
        int unsigned      node;
        nb   = bits;
        node = 0;
        for (int l = 0; l < IDX_W; l++) begin
            nb[node] = ~way[IDX_W-1-l];
            node     = 2 * node + 1 + 32'(way[IDX_W-1-l]);
        end
        return nb;
    endfunction

    function automatic logic [IDX_W-1:0] find_victim(input logic [DEPTH-2:0] bits);
        logic [IDX_W-1:0] way;
        int unsigned      node;
        way  = '0;
        node = 0;
        for (int l = 0; l < IDX_W; l++) begin
            way[IDX_W-1-l] = bits[node];
            node           = 2 * node + 1 + 32'(bits[node]);
        end
        return way;
    endfunction

    always_comb begin
        plru_d = plru_q;
        if (touch_a_i) plru_d = touch(plru_d, way_a_i);
        if (touch_b_i) plru_d = touch(plru_d, way_b_i);
        // refill last so the new entry is the most recent.
        if (touch_fill_i) plru_d = touch(plru_d, way_fill_i);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            plru_q <= '0;
        end else begin
            plru_q <= plru_d;
        end
    end

    assign victim_o = find_victim(plru_q);

endmodule

`default_nettype wire

// File: source/l2_bus_pkg.sv
`default_nettype none

package l2_bus_pkg;

    // which port issued the miss.
    typedef enum logic {
        SRC_LOAD  = 1'b0,
        SRC_STORE = 1'b1
    } src_e;

    typedef struct packed {
        src_e           src;
        dtlb_pkg::vpn_t vpn;
    } l2_req_t;

    // error set means no translation, nothing is written.
    typedef struct packed {
        src_e           src;
        dtlb_pkg::vpn_t vpn;
        dtlb_pkg::ppn_t ppn;
        logic           g;
        logic           error;
    } l2_resp_t;

endpackage

`default_nettype wire

// File: source/dtlb_pkg.sv
`default_nettype none

package dtlb_pkg;

    // ------------------------------------------------------------
    // address fields.
    // ------------------------------------------------------------
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [8:0]  asid_t;

    // 4 KiB pages only.
    localparam int PAGE_OFFSET = 12;

    // ------------------------------------------------------------
    // entry and fence request.
    // ------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        vpn_t  vpn;
        ppn_t  ppn;
        asid_t asid;
        logic  g;
    } tlb_entry_t;

    typedef struct packed {
        logic  all_addr;
        logic  all_asid;
        vpn_t  vpn;
        asid_t asid;
    } fence_req_t;

endpackage

`default_nettype wire
